// File: Makefile
VERILATOR ?= verilator
TOP       ?= y_scan_tb
FLIST     ?= y_scan.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/dac_spi_writer.sv
`timescale 1ns/100ps
`default_nettype none

`include "y_scan_defs.svh"

module dac_spi_writer (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [`Y_DAC_W-1:0] code,
    output logic                busy,
    output logic                cs_n,
    output logic                sclk,
    output logic                mosi
);
    import y_scan_pkg::*;

    dac_frame_t frame;
    logic [4:0] bit_cnt;   // bits left after the current one

    assign mosi = frame[`Y_SPI_BITS-1];

    // shift register, advances on each falling sclk edge
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            frame.cmd  <= `Y_DAC_CMD;
            frame.code <= code;
        end else if (!cs_n && sclk && bit_cnt != 5'd0) begin
            frame <= dac_frame_t'({frame[`Y_SPI_BITS-2:0], 1'b0});
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            cs_n    <= 1'b1;
            sclk    <= 1'b0;
            bit_cnt <= 5'd0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= 5'(`Y_SPI_BITS - 1);
            end
        end else if (cs_n) begin
            cs_n <= 1'b0;   // first bit already on mosi
        end else if (!sclk) begin
            sclk <= 1'b1;
        end else begin
            sclk <= 1'b0;
            if (bit_cnt == 5'd0) begin
                cs_n <= 1'b1;
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt - 5'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/ramp_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "y_scan_defs.svh"

interface ramp_ctrl_if;
    logic [`Y_PIX_W-1:0]  pixel_count;
    logic [`Y_STEP_W-1:0] step;
    logic                 start_cmd;   // single-cycle pulses
    logic                 stop_cmd;
    logic                 running;
    logic                 stopped;
    logic                 acquire;
    logic                 direction;

    modport regs (
        output pixel_count, step, start_cmd, stop_cmd,
        input  running, stopped, acquire, direction
    );

    modport engine (
        input  pixel_count, step, start_cmd, stop_cmd,
        output running, stopped, acquire, direction
    );
endinterface

`default_nettype wire

// File: logic/scan_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "y_scan_defs.svh"

module scan_regs (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [$bits(y_scan_pkg::scan_reg_addr_e)-1:0] paddr,
    input  logic [31:0]                                   pwdata,
    output logic [31:0]                                   prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    ramp_ctrl_if.regs                                     ctrl
);
    import y_scan_pkg::*;

    logic access;
    logic wr_access;
    logic addr_hit;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign pready    = 1'b1;   // no wait states

    // writes land at the end of the access cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.pixel_count <= '0;
            ctrl.step        <= '0;
            ctrl.start_cmd   <= 1'b0;
            ctrl.stop_cmd    <= 1'b0;
        end else begin
            ctrl.start_cmd <= wr_access && (paddr == addr_ctrl) && pwdata[0];
            ctrl.stop_cmd  <= wr_access && (paddr == addr_ctrl) && pwdata[1];
            if (wr_access) begin
                case (paddr)
                    addr_pixels: ctrl.pixel_count <= pwdata[`Y_PIX_W-1:0];
                    addr_step:   ctrl.step <= pwdata[`Y_STEP_W-1:0];
                    default: ;   // ctrl handled above, status is read-only
                endcase
            end
        end
    end

    // read mux, valid during the access cycle
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            addr_ctrl: begin
                prdata = '0;   // command bits read back as zero
            end
            addr_pixels: begin
                prdata = {{(32-`Y_PIX_W){1'b0}}, ctrl.pixel_count};
            end
            addr_step: begin
                prdata = {{(32-`Y_STEP_W){1'b0}}, ctrl.step};
            end
            addr_status: begin
                prdata = {28'd0, ctrl.direction, ctrl.acquire, ctrl.stopped, ctrl.running};
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    assign pslverr = access && !addr_hit;

endmodule

`default_nettype wire

// File: logic/y_ramp_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "y_scan_defs.svh"

module y_ramp_engine (
    input  logic                clk,
    input  logic                reset,
    input  logic                start_y,
    input  logic                pos_peak,
    input  logic                neg_peak,
    input  logic                dac_busy,
    ramp_ctrl_if.engine         ctrl,
    output logic                dac_start,
    output logic [`Y_DAC_W-1:0] dac_code,
    output logic                stop_xz
);
    import y_scan_pkg::*;

    typedef enum logic [1:0] {
        upd_off,
        upd_write,
        upd_step
    } upd_state_e;

    ramp_state_e          state;
    upd_state_e           upd_state;
    logic [`Y_ACC_W-1:0]  acc;
    logic [`Y_ACC_W-1:0]  step_ext;
    logic [`Y_PIX_W-1:0]  pix_cnt;
    logic [`Y_PIX_W-1:0]  pix_load;
    logic                 direction;   // 1 = ramping up
    logic                 acquire;
    logic                 sync_peak;
    logic                 stop_pending;

    assign step_ext = {{(`Y_ACC_W-`Y_STEP_W){1'b0}}, ctrl.step};

    // even pixel counts sync on the positive peak, odd ones on the negative
    assign sync_peak = ctrl.pixel_count[0] ? neg_peak : pos_peak;
    assign pix_load  = ctrl.pixel_count[0] ? (ctrl.pixel_count >> 1)
                                           : (ctrl.pixel_count >> 1) - `Y_PIX_W'(1);

    assign stop_pending = ctrl.stop_cmd || (state == st_wait_window_end)
                          || (state == st_return_mid);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            stop_xz <= 1'b0;
        end else begin
            stop_xz <= 1'b0;
            case (state)
                st_idle: if (ctrl.start_cmd) state <= st_arm;
                st_arm: begin
                    if (ctrl.stop_cmd) state <= st_idle;
                    else if (start_y) state <= st_wait_sync;
                end
                st_wait_sync: begin
                    if (ctrl.stop_cmd) state <= st_idle;
                    else if (sync_peak) state <= st_acquisition;
                end
                st_acquisition: if (ctrl.stop_cmd) state <= st_wait_window_end;
                st_wait_window_end: if (!acquire) state <= st_return_mid;
                st_return_mid: begin
                    // done once the mid-scale word has gone out
                    if (dac_start && acc == `Y_ACC_MID) begin
                        state   <= st_idle;
                        stop_xz <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            upd_state <= upd_off;
            acc       <= `Y_ACC_MID;
            pix_cnt   <= '0;
            direction <= 1'b1;
            acquire   <= 1'b0;
            dac_start <= 1'b0;
        end else begin
            case (upd_state)
                upd_off: begin
                    acc       <= `Y_ACC_MID;
                    pix_cnt   <= pix_load;
                    direction <= 1'b1;
                    acquire   <= 1'b0;
                    dac_start <= 1'b0;
                    if (state == st_acquisition) upd_state <= upd_write;
                end
                upd_write: begin
                    if (state == st_idle) begin
                        upd_state <= upd_off;
                    end else if (!dac_busy) begin
                        dac_start <= 1'b1;
                        upd_state <= upd_step;
                    end
                end
                upd_step: begin
                    dac_start <= 1'b0;
                    acc <= direction ? acc + step_ext : acc - step_ext;
                    if (pos_peak) begin
                        if (pix_cnt == '0) begin
                            // up-going reversal opens a new window unless stopping
                            if (direction) acquire <= !stop_pending;
                            pix_cnt   <= ctrl.pixel_count - `Y_PIX_W'(1);
                            direction <= !direction;
                        end else begin
                            pix_cnt <= pix_cnt - `Y_PIX_W'(1);
                        end
                    end
                    upd_state <= upd_write;
                end
                default: upd_state <= upd_off;
            endcase
        end
    end

    assign dac_code       = acc[`Y_ACC_W-1 -: `Y_DAC_W];
    assign ctrl.running   = (state == st_acquisition);
    assign ctrl.stopped   = (state == st_idle);
    assign ctrl.acquire   = acquire;
    assign ctrl.direction = direction;

endmodule

`default_nettype wire

// File: logic/y_scan_defs.svh
`ifndef Y_SCAN_DEFS_SVH
`define Y_SCAN_DEFS_SVH

// datapath widths
`define Y_ACC_W     40
`define Y_DAC_W     16
`define Y_STEP_W    32
`define Y_PIX_W     16

// accumulator value that maps to dac code 0x8000
`define Y_ACC_MID   40'h80_0000_0000

`define Y_DAC_CMD   8'h30   // write and update channel
`define Y_SPI_BITS  24      // command byte + 16-bit code

`endif

// File: logic/y_scan_pkg.sv
`default_nettype none

`include "y_scan_defs.svh"

package y_scan_pkg;

    // apb word addresses
    typedef enum logic [7:0] {
        addr_ctrl   = 8'h00,
        addr_pixels = 8'h04,
        addr_step   = 8'h08,
        addr_status = 8'h0C
    } scan_reg_addr_e;

    typedef enum logic [2:0] {
        st_idle,
        st_arm,
        st_wait_sync,
        st_acquisition,
        st_wait_window_end,
        st_return_mid
    } ramp_state_e;

    // one spi frame, sent msb first
    typedef struct packed {
        logic [7:0]          cmd;
        logic [`Y_DAC_W-1:0] code;
    } dac_frame_t;

endpackage

`default_nettype wire

// File: logic/y_scan_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "y_scan_defs.svh"

module y_scan_top (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [$bits(y_scan_pkg::scan_reg_addr_e)-1:0] paddr,
    input  logic [31:0]                                   pwdata,
    output logic [31:0]                                   prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    input  logic                                          start_y,
    input  logic                                          pos_peak,
    input  logic                                          neg_peak,
    output logic                                          dac_cs_n,
    output logic                                          dac_sclk,
    output logic                                          dac_mosi,
    output logic                                          stop_xz,
    output logic                                          adc_acquire
);
    logic                dac_start;
    logic                dac_busy;
    logic [`Y_DAC_W-1:0] dac_code;

    ramp_ctrl_if ctrl_bus ();

    scan_regs scan_regs_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl_bus.regs)
    );

    y_ramp_engine y_ramp_engine_inst (
        .clk       (clk),
        .reset     (reset),
        .start_y   (start_y),
        .pos_peak  (pos_peak),
        .neg_peak  (neg_peak),
        .dac_busy  (dac_busy),
        .ctrl      (ctrl_bus.engine),
        .dac_start (dac_start),
        .dac_code  (dac_code),
        .stop_xz   (stop_xz)
    );

    dac_spi_writer dac_spi_writer_inst (
        .clk   (clk),
        .reset (reset),
        .start (dac_start),
        .code  (dac_code),
        .busy  (dac_busy),
        .cs_n  (dac_cs_n),
        .sclk  (dac_sclk),
        .mosi  (dac_mosi)
    );

    assign adc_acquire = ctrl_bus.acquire;

endmodule

`default_nettype wire

// File: testbench/y_scan_props.sv
`timescale 1ns/100ps
`default_nettype none

module y_scan_props (
    input logic                     clk,
    input logic                     reset,
    input logic                     dac_start,
    input logic                     dac_busy,
    input logic                     cs_n,
    input logic                     stop_xz,
    input y_scan_pkg::ramp_state_e  state
);
    import y_scan_pkg::*;

    int low_cnt;   // cycles with cs_n low in the current frame

    always_ff @(posedge clk) begin
        if (reset || cs_n) low_cnt <= 0;
        else low_cnt <= low_cnt + 1;
    end

    start_when_idle: assert property (@(posedge clk) disable iff (reset)
        !(dac_start && dac_busy))
        else $error("dac_start raised while the spi writer is busy");

    frame_length: assert property (@(posedge clk) disable iff (reset)
        $rose(cs_n) |-> low_cnt == 48)
        else $error("cs_n low for %0d cycles instead of 48", $sampled(low_cnt));

    stop_pulse: assert property (@(posedge clk) disable iff (reset)
        stop_xz |-> (state == st_idle) ##1 !stop_xz)
        else $error("stop_xz not a single-cycle pulse with the engine idle");

endmodule

bind y_scan_top y_scan_props props_inst (
    .clk       (clk),
    .reset     (reset),
    .dac_start (dac_start),
    .dac_busy  (dac_busy),
    .cs_n      (dac_cs_n),
    .stop_xz   (stop_xz),
    .state     (y_ramp_engine_inst.state)
);

`default_nettype wire

// File: testbench/y_scan_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "y_scan_defs.svh"

module y_scan_tb;
    import y_scan_pkg::*;

    // worst case: 1 + 3 + (2*17+2) + 1 + (4*17+4) frames, rounded up
    localparam int MAX_FRAMES  = 120;
    localparam int CYCLE_LIMIT = 4 * MAX_FRAMES * 50;

    logic        clk, reset, psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    logic        start_y, pos_peak, neg_peak;
    logic        dac_cs_n, dac_sclk, dac_mosi, stop_xz, adc_acquire;

    integer      seed = 6;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    int          stop_count = 0;
    logic [15:0] pixels;
    logic [15:0] kstep;        // code units per update
    logic [15:0] m_code;       // model of the ramp
    logic        m_dir, m_acq, m_stopping;
    int          m_cnt;

    y_scan_top y_scan_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge clk) if (!reset && stop_xz) stop_count++;

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_frame(string name, dac_frame_t got, dac_frame_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%06h expected 0x%06h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests++;
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    task automatic apb_write(logic [7:0] addr, logic [31:0] data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        check_bit("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(logic [7:0] addr, output logic [31:0] data, output logic err);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        check_bit("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic pulse_inputs(logic sy, logic pp, logic np);
        @(negedge clk);
        start_y  = sy;
        pos_peak = pp;
        neg_peak = np;
        @(negedge clk);
        start_y  = 1'b0;
        pos_peak = 1'b0;
        neg_peak = 1'b0;
    endtask

    task automatic receive_frame(output dac_frame_t f);
        f = '0;
        while (dac_cs_n) @(negedge clk);
        for (int i = 0; i < `Y_SPI_BITS; i++) begin
            @(posedge dac_sclk);
            f = dac_frame_t'({f[`Y_SPI_BITS-2:0], dac_mosi});
        end
        while (!dac_cs_n) @(negedge clk);
    endtask

    task automatic expect_no_frame(int n);
        logic quiet;
        quiet = 1'b1;
        repeat (n) begin
            @(negedge clk);
            quiet &= dac_cs_n;
        end
        check_bit("dac_cs_n", quiet, 1'b1);
    endtask

    // one ramp update as the engine applies it right after the frame starts
    task automatic model_update(logic peak);
        m_code = m_dir ? m_code + kstep : m_code - kstep;
        if (peak) begin
            if (m_cnt == 0) begin
                if (m_dir) m_acq = !m_stopping;
                m_cnt = pixels - 1;
                m_dir = !m_dir;
            end else begin
                m_cnt--;
            end
        end
    endtask

    task automatic take_frame();
        dac_frame_t f;
        receive_frame(f);
        check_frame("dac frame", f, {`Y_DAC_CMD, m_code});
        model_update(pos_peak);
        check_bit("adc_acquire", adc_acquire, m_acq);
    endtask

    task automatic test_registers();
        int e;
        logic [31:0] rd;
        logic err;
        e = errors;
        apb_read(addr_status, rd, err);
        check_bit("status.stopped", rd[1], 1'b1);
        check_bit("status.running", rd[0], 1'b0);
        apb_write(addr_pixels, {16'd0, pixels});
        apb_write(addr_step, {kstep[7:0], 24'd0});
        apb_read(addr_pixels, rd, err);
        check_word("pixels", rd, {16'd0, pixels});
        apb_read(addr_step, rd, err);
        check_word("step", rd, {kstep[7:0], 24'd0});
        apb_read(8'h10, rd, err);
        check_bit("pslverr", err, 1'b1);
        report_test("registers", e);
    endtask

    task automatic test_sync();
        int e;
        logic odd;
        e = errors;
        odd        = pixels[0];
        m_code     = 16'h8000;
        m_dir      = 1'b1;
        m_acq      = 1'b0;
        m_stopping = 1'b0;
        m_cnt      = odd ? pixels / 2 : pixels / 2 - 1;
        apb_write(addr_ctrl, 32'h1);
        pulse_inputs(1'b0, !odd, odd);    // matching peak before start_y is ignored
        expect_no_frame(20);
        pulse_inputs(1'b1, 1'b0, 1'b0);
        pulse_inputs(1'b0, odd, !odd);    // wrong peak
        expect_no_frame(60);
        pulse_inputs(1'b0, !odd, odd);
        take_frame();
        report_test("sync and first frame", e);
    endtask

    task automatic test_slope();
        int e;
        e = errors;
        repeat (3) take_frame();
        report_test("ramp slope", e);
    endtask

    task automatic test_reversal();
        int e;
        e = errors;
        @(negedge clk);
        pos_peak = 1'b1;
        repeat (2 * pixels + 2) take_frame();
        check_bit("adc_acquire", adc_acquire, 1'b1);
        report_test("reversal and acquire", e);
    endtask

    task automatic test_stop();
        int e;
        int n;
        logic returning, done;
        logic [15:0] exp_code;
        logic [31:0] rd;
        logic err;
        e = errors;
        apb_write(addr_ctrl, 32'h2);
        take_frame();                 // its update came before the stop pulse
        m_stopping = 1'b1;
        returning  = !m_acq;
        done       = 1'b0;
        n          = 0;
        while (!done && n < 4 * pixels + 4) begin
            exp_code = m_code;
            take_frame();
            n++;
            if (returning && exp_code == 16'h8000) done = 1'b1;
            else if (!m_acq) returning = 1'b1;
        end
        if (!done) begin
            errors++;
            $display("stop: ramp never returned to mid-scale");
        end
        check_word("stop_xz pulses", stop_count, 32'd1);
        apb_read(addr_status, rd, err);
        check_bit("status.stopped", rd[1], 1'b1);
        check_bit("status.running", rd[0], 1'b0);
        expect_no_frame(150);
        report_test("stop", e);
    endtask

    initial begin
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        start_y  = 1'b0;
        pos_peak = 1'b0;
        neg_peak = 1'b0;
        pixels   = 16'(10 + ({$random(seed)} % 8));
        kstep    = 16'(1 + ({$random(seed)} % 255));
        repeat (10) @(negedge clk);
        reset = 1'b0;
        test_registers();
        test_sync();
        test_slope();
        test_reversal();
        test_stop();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: y_scan.f
+incdir+logic
logic/y_scan_pkg.sv
logic/ramp_ctrl_if.sv
logic/scan_regs.sv
logic/y_ramp_engine.sv
logic/dac_spi_writer.sv
logic/y_scan_top.sv
testbench/y_scan_props.sv
testbench/y_scan_tb.sv
